//--- hdl/div_pkg.sv
package div_pkg;

    localparam int xlen = 32;
    localparam int bit_count_w = 6; // holds 0..32

    // operands from the execute stage
    typedef struct packed
    {
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
        logic            is_signed; // DIV vs DIVU
    } div_req_t;

    // quotient goes to LO, remainder to HI
    typedef struct packed
    {
        logic [xlen-1:0] quotient;
        logic [xlen-1:0] remainder;
    } div_result_t;

    // direct move target for MTHI / MTLO
    typedef enum logic [1:0]
    {
        none  = 2'd0,
        to_hi = 2'd1,
        to_lo = 2'd2
    } hilo_wsel_t;

endpackage

//--- hdl/bit_length.sv
`timescale 1ns/1ps

// number of significant bits of an unsigned word
module bit_length
(
    input  logic [div_pkg::xlen-1:0]        in,
    output logic [div_pkg::bit_count_w-1:0] len
);

    always_comb
    begin
        len = '0; // zero input has no set bit
        // ascending scan so the highest set bit wins
        for (int i = 0; i < div_pkg::xlen; i++)
        begin
            if (in[i])
            begin
                len = div_pkg::bit_count_w'(i + 1);
            end
        end
    end

endmodule

//--- hdl/divider.sv
`timescale 1ns/1ps

module divider
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  logic                start,
    input  div_pkg::div_req_t   req,
    output logic                stall,
    output logic                done,
    output div_pkg::div_result_t result
);

    typedef enum logic [1:0]
    {
        idle_s,
        init_s,
        calc_s,
        done_s
    } div_state_t;

    div_state_t state;
    div_state_t next_state;

    logic [div_pkg::xlen-1:0]        dd_abs;
    logic [div_pkg::xlen-1:0]        dv_abs;
    logic [div_pkg::bit_count_w-1:0] dd_len_in;
    logic [div_pkg::bit_count_w-1:0] dv_len_in;

    logic [div_pkg::bit_count_w-1:0] dd_len;
    logic [div_pkg::bit_count_w-1:0] dv_len;
    logic [div_pkg::bit_count_w-1:0] last_count;
    logic [div_pkg::bit_count_w-1:0] count;
    logic [div_pkg::xlen-1:0]        dv_mag;
    logic                            dd_neg;
    logic                            dv_neg;
    logic                            early;

    logic [2*div_pkg::xlen-1:0] rem_reg; // partial remainder
    logic [2*div_pkg::xlen-1:0] div_reg; // aligned divisor
    logic [2*div_pkg::xlen-1:0] minus;
    logic [div_pkg::xlen-1:0]   q_reg;
    logic [div_pkg::xlen-1:0]   q_nxt;

    assign dd_abs = (req.is_signed && req.dividend[div_pkg::xlen-1]) ?
                    -req.dividend : req.dividend;
    assign dv_abs = (req.is_signed && req.divisor[div_pkg::xlen-1]) ?
                    -req.divisor : req.divisor;

    bit_length dd_len_inst
    (
        .in  (dd_abs),
        .len (dd_len_in)
    );

    bit_length dv_len_inst
    (
        .in  (dv_abs),
        .len (dv_len_in)
    );

    assign early      = (dv_len == '0) || (dv_len > dd_len); // div by zero or q = 0
    assign last_count = dd_len - dv_len + div_pkg::bit_count_w'(1);
    assign minus      = rem_reg - div_reg;
    assign q_nxt      = {q_reg[div_pkg::xlen-2:0], ~minus[2*div_pkg::xlen-1]};

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= idle_s;
        end
        else if (flush)
        begin
            state <= idle_s; // drop the division in flight
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            idle_s:
            begin
                if (start)
                begin
                    next_state = init_s;
                end
            end
            init_s:
            begin
                next_state = early ? done_s : calc_s;
            end
            calc_s:
            begin
                if (count == last_count)
                begin
                    next_state = done_s;
                end
            end
            default:
            begin
                next_state = idle_s;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        case (state)
            idle_s:
            begin
                if (start)
                begin
                    rem_reg <= {{div_pkg::xlen{1'b0}}, dd_abs};
                    dv_mag  <= dv_abs;
                    dd_len  <= dd_len_in;
                    dv_len  <= dv_len_in;
                    dd_neg  <= req.is_signed & req.dividend[div_pkg::xlen-1];
                    dv_neg  <= req.is_signed & req.divisor[div_pkg::xlen-1];
                end
            end
            init_s:
            begin
                q_reg   <= '0;
                count   <= '0;
                // one position above the dividend's leading one
                div_reg <= {{div_pkg::xlen{1'b0}}, dv_mag} << last_count;
            end
            calc_s:
            begin
                q_reg   <= q_nxt;
                count   <= count + div_pkg::bit_count_w'(1);
                div_reg <= {1'b0, div_reg[2*div_pkg::xlen-1:1]};
                if (!minus[2*div_pkg::xlen-1])
                begin
                    rem_reg <= minus; // subtract fits
                end
            end
            default:
            begin
            end
        endcase
    end

    // sign fix-up during the done cycle
    assign result.quotient  = (dd_neg ^ dv_neg) ? -q_reg : q_reg;
    assign result.remainder = dd_neg ? -rem_reg[div_pkg::xlen-1:0] :
                              rem_reg[div_pkg::xlen-1:0];

    assign stall = (state != idle_s);
    assign done  = (state == done_s) && !flush; // flushed result never lands

endmodule

//--- hdl/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     res_valid,
    input  div_pkg::div_result_t     res,
    input  div_pkg::hilo_wsel_t      wsel,
    input  logic [div_pkg::xlen-1:0] wdata,
    output logic [div_pkg::xlen-1:0] hi,
    output logic [div_pkg::xlen-1:0] lo
);

    // HI holds the remainder
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hi <= '0;
        end
        else if (res_valid)
        begin
            hi <= res.remainder; // division beats a move
        end
        else if (wsel == div_pkg::to_hi)
        begin
            hi <= wdata;
        end
    end

    // LO holds the quotient
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            lo <= '0;
        end
        else if (res_valid)
        begin
            lo <= res.quotient;
        end
        else if (wsel == div_pkg::to_lo)
        begin
            lo <= wdata;
        end
    end

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     start,
    input  div_pkg::div_req_t        req,
    input  div_pkg::hilo_wsel_t      wsel,
    input  logic [div_pkg::xlen-1:0] wdata,
    output logic                     stall,
    output logic                     done,
    output logic [div_pkg::xlen-1:0] hi,
    output logic [div_pkg::xlen-1:0] lo
);

    logic                 div_done;
    div_pkg::div_result_t div_result;

    divider divider_inst
    (
        .clk    (clk),
        .rstn   (rstn),
        .flush  (flush),
        .start  (start),
        .req    (req),
        .stall  (stall), // holds the pipeline
        .done   (div_done),
        .result (div_result)
    );

    hilo_regs hilo_regs_inst
    (
        .clk       (clk),
        .rstn      (rstn),
        .res_valid (div_done),
        .res       (div_result),
        .wsel      (wsel),
        .wdata     (wdata),
        .hi        (hi),
        .lo        (lo)
    );

    assign done = div_done;

endmodule

//--- test/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

    logic                     clk;
    logic                     rstn;
    logic                     flush;
    logic                     start;
    div_pkg::div_req_t        req;
    div_pkg::hilo_wsel_t      wsel;
    logic [div_pkg::xlen-1:0] wdata;
    logic                     stall;
    logic                     done;
    logic [div_pkg::xlen-1:0] hi;
    logic [div_pkg::xlen-1:0] lo;

    string       ops[$];
    logic [31:0] opa[$];
    logic [31:0] opb[$];
    logic [31:0] want_lo[$];
    logic [31:0] want_hi[$];

    int errors = 0;
    int checks = 0;
    int cur_test = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int n_tests = 0;

    div_unit div_unit_inst
    (
        .clk   (clk),
        .rstn  (rstn),
        .flush (flush),
        .start (start),
        .req   (req),
        .wsel  (wsel),
        .wdata (wdata),
        .stall (stall),
        .done  (done),
        .hi    (hi),
        .lo    (lo)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: test %0d %s, got %h expected %h",
                     $time, cur_test, what, actual, expected);
        end
    endtask

    // significant bits, counted by shifting down to zero
    function automatic int bit_len(input logic [31:0] v);
        int n;
        n = 0;
        while (v != 0)
        begin
            v = v >> 1;
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] magnitude(input logic [31:0] v, input logic sgn);
        return (sgn && v[31]) ? (~v + 32'd1) : v;
    endfunction

    // cycles from the start edge to the done pulse
    function automatic int expected_latency(input logic sgn, input logic [31:0] a,
                                            input logic [31:0] b);
        int dd_len;
        int dv_len;
        dd_len = bit_len(magnitude(a, sgn));
        dv_len = bit_len(magnitude(b, sgn));
        return (dv_len == 0 || dv_len > dd_len) ? 2 : dd_len - dv_len + 4;
    endfunction

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          got;
        string       line;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] lo_v;
        logic [31:0] hi_v;
        fd = $fopen("test/div_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok)
        begin
            while (!$feof(fd))
            begin
                got = $fgets(line, fd);
                if (got != 0 && line.getc(0) != "#") // skip column notes
                begin
                    got = $sscanf(line, "%s %h %h %h %h", op, a, b, lo_v, hi_v);
                    if (got == 5)
                    begin
                        ops.push_back(op);
                        opa.push_back(a);
                        opb.push_back(b);
                        want_lo.push_back(lo_v);
                        want_hi.push_back(hi_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic divide_and_check(input logic sgn, input logic [31:0] a,
                                    input logic [31:0] b, input logic [31:0] exp_lo,
                                    input logic [31:0] exp_hi);
        int want_lat;
        int lat;
        want_lat = expected_latency(sgn, a, b);
        @(posedge clk);
        start <= 1'b1;
        req.dividend <= a;
        req.divisor <= b;
        req.is_signed <= sgn;
        @(posedge clk);
        start <= 1'b0;
        lat = 1; // init cycle
        @(negedge clk);
        while (!done)
        begin
            check_value(stall, 1, "stall while busy");
            lat++;
            @(negedge clk);
        end
        check_value(stall, 1, "stall in done cycle");
        check_value(lat, want_lat, "cycles from start to done");
        @(negedge clk);
        check_value(done, 0, "done longer than one cycle");
        check_value(stall, 0, "stall after done");
        check_value(lo, exp_lo, "LO");
        check_value(hi, exp_hi, "HI");
    endtask

    task automatic move_and_check(input div_pkg::hilo_wsel_t sel, input logic [31:0] a,
                                  input logic [31:0] exp_lo, input logic [31:0] exp_hi);
        @(posedge clk);
        wsel <= sel;
        wdata <= a;
        @(posedge clk);
        wsel <= div_pkg::none;
        @(negedge clk);
        check_value(lo, exp_lo, "LO after move");
        check_value(hi, exp_hi, "HI after move");
    endtask

    // starts a divu and flushes it after busy cycles of stall
    task automatic cancel_division(input logic [31:0] a, input logic [31:0] b,
                                   input int busy, input logic [31:0] exp_lo,
                                   input logic [31:0] exp_hi);
        @(posedge clk);
        start <= 1'b1;
        req.dividend <= a;
        req.divisor <= b;
        req.is_signed <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
        repeat (busy)
        begin
            @(negedge clk);
            check_value(stall, 1, "stall before flush");
            check_value(done, 0, "done before flush");
            @(posedge clk);
        end
        flush <= 1'b1;
        @(negedge clk);
        check_value(done, 0, "done during flush");
        @(posedge clk);
        flush <= 1'b0;
        repeat (4) // divider must stay idle
        begin
            @(negedge clk);
            check_value(stall, 0, "stall after flush");
            check_value(done, 0, "done after flush");
        end
        check_value(lo, exp_lo, "LO kept over flush");
        check_value(hi, exp_hi, "HI kept over flush");
    endtask

    initial
    begin
        bit file_ok;
        clk = 1'b0;
        rstn = 1'b0;
        flush = 1'b0;
        start = 1'b0;
        req = '0;
        wsel = div_pkg::none;
        wdata = '0;
        load_stimulus(file_ok);
        n_tests = ops.size();
        cycle_limit = n_tests * 40 + 16;
        if (file_ok && n_tests > 0)
        begin
            repeat (16) @(posedge clk);
            rstn <= 1'b1;
            @(negedge clk);
            check_value(stall, 0, "stall after reset");
            check_value(done, 0, "done after reset");
            check_value(lo, 0, "LO after reset");
            check_value(hi, 0, "HI after reset");
            for (int i = 0; i < n_tests; i++)
            begin
                cur_test = i + 1;
                if (ops[i] == "divu")
                    divide_and_check(1'b0, opa[i], opb[i], want_lo[i], want_hi[i]);
                else if (ops[i] == "div")
                    divide_and_check(1'b1, opa[i], opb[i], want_lo[i], want_hi[i]);
                else if (ops[i] == "mthi")
                    move_and_check(div_pkg::to_hi, opa[i], want_lo[i], want_hi[i]);
                else if (ops[i] == "mtlo")
                    move_and_check(div_pkg::to_lo, opa[i], want_lo[i], want_hi[i]);
                else if (ops[i] == "flush")
                begin
                    cancel_division(opa[i], opb[i], 2, want_lo[i], want_hi[i]);
                    // second run lands the flush on the done cycle
                    cancel_division(opa[i], opb[i],
                                    expected_latency(1'b0, opa[i], opb[i]) - 1,
                                    want_lo[i], want_hi[i]);
                end
                else
                begin
                    errors++;
                    $display("test %0d has an unknown operation %s", cur_test, ops[i]);
                end
            end
        end
        else
        begin
            errors++;
            $display("could not read any tests from test/div_stimulus.txt");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- test/div_stimulus.txt
# op dividend divisor expected_lo expected_hi, all in hex
# mthi and mtlo write the dividend column, flush starts a divu and cancels it
divu 00000064 00000007 0000000e 00000002
divu 12345678 00000001 12345678 00000000
divu 0000abcd 0000abcd 00000001 00000000
divu ffffffff 00000010 0fffffff 0000000f
divu ffffffff fffffffe 00000001 00000001
divu 80000000 00000003 2aaaaaaa 00000002
divu ffffffff 0000ffff 00010001 00000000
divu deadbeef 00010000 0000dead 0000beef
divu 00000005 00000006 00000000 00000005
div 00000007 00000002 00000003 00000001
div fffffff9 00000002 fffffffd ffffffff
div 00000007 fffffffe fffffffd 00000001
div fffffff9 fffffffe 00000003 ffffffff
div 80000000 00000002 c0000000 00000000
div fffffc18 00000064 fffffff6 00000000
div 7fffffff ffffffff 80000001 00000000
divu 00000005 00000009 00000000 00000005
divu 12345678 00000000 00000000 12345678
div fffffff6 00000000 00000000 fffffff6
div fffffffb 00000040 00000000 fffffffb
mthi 11111111 00000000 00000000 11111111
mtlo 22222222 00000000 22222222 11111111
flush ffffffff 00000003 22222222 11111111
divu 00000064 00000009 0000000b 00000001
mtlo cafef00d 00000000 cafef00d 00000001
div ffffff9c 00000009 fffffff5 ffffffff

//--- sources.f
hdl/div_pkg.sv
hdl/bit_length.sv
hdl/divider.sv
hdl/hilo_regs.sv
hdl/div_unit.sv
test/div_unit_tb.sv

//--- Bender.yml
package:
  name: div_unit

dependencies: {}

sources:
  - hdl/div_pkg.sv
  - hdl/bit_length.sv
  - hdl/divider.sv
  - hdl/hilo_regs.sv
  - hdl/div_unit.sv
  - target: test
    files:
      - test/div_unit_tb.sv
